// ==== mshr_pkg.sv ====
package mshr_pkg;

    // address breakdown of a line address
    localparam int TAG_W  = 10;
    localparam int SET_W  = 4;
    localparam int WOFF_W = 2;

    // payload widths
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int WAY_W          = 3;
    localparam int CPU_MSG_W      = 2;

    // code widths
    localparam int STATE_W = 4;
    localparam int MSG_W   = 5;
    localparam int CMD_W   = 3;

    // unstable states, SPX_I marks a free entry
    localparam logic [STATE_W-1:0] SPX_I   = 4'd0;
    localparam logic [STATE_W-1:0] SPX_IS  = 4'd1;
    localparam logic [STATE_W-1:0] SPX_RI  = 4'd2;
    localparam logic [STATE_W-1:0] SPX_XR  = 4'd3;
    localparam logic [STATE_W-1:0] SPX_XRV = 4'd4;
    localparam logic [STATE_W-1:0] SPX_AMO = 4'd5;

    // forward messages from the directory
    localparam logic [MSG_W-1:0] FWD_REQ_S     = 5'd0;
    localparam logic [MSG_W-1:0] FWD_REQ_O     = 5'd1;
    localparam logic [MSG_W-1:0] FWD_INV       = 5'd2;
    localparam logic [MSG_W-1:0] FWD_RVK_O     = 5'd3;
    localparam logic [MSG_W-1:0] FWD_REQ_ODATA = 5'd4;
    localparam logic [MSG_W-1:0] FWD_WTFWD     = 5'd5;

    // command kinds, searches first, then writes
    localparam logic [CMD_W-1:0] CMD_LOOKUP     = 3'd0;
    localparam logic [CMD_W-1:0] CMD_PEEK_REQ   = 3'd1;
    localparam logic [CMD_W-1:0] CMD_PEEK_FLUSH = 3'd2;
    localparam logic [CMD_W-1:0] CMD_PEEK_FWD   = 3'd3;
    localparam logic [CMD_W-1:0] CMD_ADD        = 3'd4;
    localparam logic [CMD_W-1:0] CMD_UPDATE     = 3'd5;

    // one buffer entry
    typedef struct packed {
        logic [STATE_W-1:0]        state;
        logic [TAG_W-1:0]          tag;
        logic [SET_W-1:0]          set;
        logic [WAY_W-1:0]          way;
        logic [WOFF_W-1:0]         w_off;
        logic [CPU_MSG_W-1:0]      cpu_msg;
        logic [WORD_W-1:0]         word;
        logic [LINE_W-1:0]         line;
        logic [WORDS_PER_LINE-1:0] word_mask;
    } mshr_entry_t;

    // one command at the port
    typedef struct packed {
        logic [CMD_W-1:0]          kind;
        logic [MSG_W-1:0]          fwd_msg;
        // address
        logic [TAG_W-1:0]          tag;
        logic [SET_W-1:0]          set;
        logic [WOFF_W-1:0]         w_off;
        // field selects for UPDATE
        logic                      upd_state;
        logic                      upd_line;
        logic                      upd_tag;
        logic                      upd_word_mask;
        // values
        logic [STATE_W-1:0]        state;
        logic [WAY_W-1:0]          way;
        logic [CPU_MSG_W-1:0]      cpu_msg;
        logic [WORD_W-1:0]         word;
        logic [LINE_W-1:0]         line;
        logic [WORDS_PER_LINE-1:0] word_mask;
    } mshr_cmd_t;

    // search flags, index travels separately
    typedef struct packed {
        logic hit;
        logic set_conflict;
        logic fwd_stall;
    } mshr_search_t;

endpackage

// ==== mshr_entry_array.sv ====
`timescale 1ns/1ps

module mshr_entry_array #(
    parameter int N_MSHR = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  accept_i,
    input  mshr_pkg::mshr_cmd_t   cmd_i,
    input  logic [IDX_W-1:0]      idx_i,
    output mshr_pkg::mshr_entry_t entries_o [N_MSHR]
);

    localparam int IDX_W = (N_MSHR > 1) ? $clog2(N_MSHR) : 1;

    mshr_pkg::mshr_entry_t entry_q [N_MSHR];

    logic is_add;
    logic is_upd;

    // write kind decode
    assign is_add = (cmd_i.kind == mshr_pkg::CMD_ADD);
    assign is_upd = (cmd_i.kind == mshr_pkg::CMD_UPDATE);

    for (genvar i = 0; i < N_MSHR; i++) begin : g_entry
        logic wr_sel;

        // this entry is the target of the accepted command
        assign wr_sel = accept_i && (idx_i == IDX_W'(i));

        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                // all zero is SPX_I, so every entry starts free
                entry_q[i] <= '0;
            end else if (wr_sel && is_add) begin
                // full fill, set and w_off from the address
                entry_q[i].state     <= cmd_i.state;
                entry_q[i].tag       <= cmd_i.tag;
                entry_q[i].set       <= cmd_i.set;
                entry_q[i].way       <= cmd_i.way;
                entry_q[i].w_off     <= cmd_i.w_off;
                entry_q[i].cpu_msg   <= cmd_i.cpu_msg;
                entry_q[i].word      <= cmd_i.word;
                entry_q[i].line      <= cmd_i.line;
                entry_q[i].word_mask <= cmd_i.word_mask;
            end else if (wr_sel && is_upd) begin
                // partial write, one flag per field
                if (cmd_i.upd_state) begin
                    entry_q[i].state <= cmd_i.state;
                end
                if (cmd_i.upd_line) begin
                    entry_q[i].line <= cmd_i.line;
                end
                // new tag comes in on the address field
                if (cmd_i.upd_tag) begin
                    entry_q[i].tag <= cmd_i.tag;
                end
                if (cmd_i.upd_word_mask) begin
                    entry_q[i].word_mask <= cmd_i.word_mask;
                end
            end
        end
    end

    assign entries_o = entry_q;

    // an accepted UPDATE must change at least one field
    a_upd_has_flag : assert property (
        @(posedge clk) disable iff (!rst)
        (accept_i && is_upd) |->
            (cmd_i.upd_state || cmd_i.upd_line || cmd_i.upd_tag || cmd_i.upd_word_mask)
    ) else $error("UPDATE accepted with no field selected");

endmodule

// ==== mshr_search.sv ====
`timescale 1ns/1ps

module mshr_search #(
    parameter int N_MSHR = 4
) (
    input  mshr_pkg::mshr_cmd_t    cmd_i,
    input  mshr_pkg::mshr_entry_t  entries_i [N_MSHR],
    output mshr_pkg::mshr_search_t result_o,
    output logic [IDX_W-1:0]       idx_next_o,
    output logic                   write_pending_o
);

    localparam int IDX_W = (N_MSHR > 1) ? $clog2(N_MSHR) : 1;

    logic [N_MSHR-1:0] valid;
    logic [N_MSHR-1:0] match;
    logic [N_MSHR-1:0] set_eq;

    // per-entry compare against the cmd address
    always_comb begin
        for (int i = 0; i < N_MSHR; i++) begin
            valid[i]  = (entries_i[i].state != mshr_pkg::SPX_I);
            set_eq[i] = valid[i] && (entries_i[i].set == cmd_i.set);
            match[i]  = set_eq[i] && (entries_i[i].tag == cmd_i.tag);
        end
    end

    // true when the forward can go ahead despite a matching entry
    function automatic logic fwd_no_stall(
        input logic [mshr_pkg::MSG_W-1:0]   msg,
        input logic [mshr_pkg::STATE_W-1:0] state
    );
        logic ri;
        ri = (state == mshr_pkg::SPX_RI);
        case (msg)
            mshr_pkg::FWD_INV:       return 1'b1;
            mshr_pkg::FWD_RVK_O:     return ri;
            mshr_pkg::FWD_REQ_S:     return ri;
            mshr_pkg::FWD_REQ_ODATA: return ri;
            mshr_pkg::FWD_WTFWD:     return ri;
            // FWD_REQ_O and unknown codes always wait
            default:                 return 1'b0;
        endcase
    endfunction

    always_comb begin
        result_o   = '0;
        idx_next_o = '0;

        case (cmd_i.kind)
            mshr_pkg::CMD_LOOKUP: begin
                // highest match wins
                for (int i = 0; i < N_MSHR; i++) begin
                    if (match[i]) begin
                        result_o.hit = 1'b1;
                        idx_next_o   = IDX_W'(i);
                    end
                end
            end
            mshr_pkg::CMD_PEEK_REQ: begin
                // highest free slot, conflict on any valid entry in the same set
                for (int i = 0; i < N_MSHR; i++) begin
                    if (!valid[i]) begin
                        idx_next_o = IDX_W'(i);
                    end
                end
                result_o.set_conflict = |set_eq;
            end
            mshr_pkg::CMD_PEEK_FLUSH: begin
                for (int i = 0; i < N_MSHR; i++) begin
                    if (!valid[i]) begin
                        idx_next_o = IDX_W'(i);
                    end
                end
            end
            mshr_pkg::CMD_PEEK_FWD: begin
                // stall decided on the state of the matched entry
                for (int i = 0; i < N_MSHR; i++) begin
                    if (match[i]) begin
                        result_o.hit       = 1'b1;
                        idx_next_o         = IDX_W'(i);
                        result_o.fwd_stall = !fwd_no_stall(cmd_i.fwd_msg, entries_i[i].state);
                    end
                end
            end
            // ADD and UPDATE search nothing
            default: begin
                result_o   = '0;
                idx_next_o = '0;
            end
        endcase
    end

    // ownership or atomic still outstanding somewhere
    always_comb begin
        write_pending_o = 1'b0;
        for (int i = 0; i < N_MSHR; i++) begin
            if (entries_i[i].state == mshr_pkg::SPX_XR ||
                entries_i[i].state == mshr_pkg::SPX_XRV ||
                entries_i[i].state == mshr_pkg::SPX_AMO) begin
                write_pending_o = 1'b1;
            end
        end
    end

    // a line lives in at most one entry, so address searches see one match at most
    always_comb begin
        if ((cmd_i.kind == mshr_pkg::CMD_LOOKUP || cmd_i.kind == mshr_pkg::CMD_PEEK_FWD) &&
            !$isunknown(match)) begin
            a_match_onehot : assert final ($onehot0(match))
                else $error("more than one entry matches the search address");
        end
    end

endmodule

// ==== mshr_cmd_ctrl.sv ====
`timescale 1ns/1ps

module mshr_cmd_ctrl #(
    parameter int N_MSHR = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_req_i,
    input  logic [mshr_pkg::CMD_W-1:0]   kind_i,
    input  mshr_pkg::mshr_search_t       result_i,
    input  logic [IDX_W-1:0]             idx_next_i,
    output logic                         cmd_ack_o,
    output logic                         accept_o,
    output mshr_pkg::mshr_search_t       result_o,
    output logic [IDX_W-1:0]             idx_o
);

    localparam int IDX_W = (N_MSHR > 1) ? $clog2(N_MSHR) : 1;

    logic                   ack_q;
    logic                   is_search;
    mshr_pkg::mshr_search_t result_q;
    logic [IDX_W-1:0]       idx_q;

    // new request seen while ack still low
    assign accept_o = cmd_req_i && !ack_q;

    // searches move the index and writes keep it
    assign is_search = (kind_i == mshr_pkg::CMD_LOOKUP) ||
                       (kind_i == mshr_pkg::CMD_PEEK_REQ) ||
                       (kind_i == mshr_pkg::CMD_PEEK_FLUSH) ||
                       (kind_i == mshr_pkg::CMD_PEEK_FWD);

    // four-phase ack follows req one edge late
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= cmd_req_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            result_q <= '0;
            idx_q    <= '0;
        end else if (accept_o) begin
            // flags always register and a write leaves them cleared
            result_q <= result_i;
            if (is_search) begin
                idx_q <= idx_next_i;
            end
        end
    end

    assign cmd_ack_o = ack_q;
    assign result_o  = result_q;
    assign idx_o     = idx_q;

    // a request stays up until ack answers it
    a_req_held : assert property (
        @(posedge clk) disable iff (!rst)
        (cmd_req_i && !ack_q) |=> cmd_req_i
    ) else $error("request dropped before ack was raised");

    // command held steady across the accepting edge
    a_cmd_stable : assert property (
        @(posedge clk) disable iff (!rst)
        ($past(accept_o) && cmd_req_i) |-> $stable(kind_i)
    ) else $error("command changed while the request was pending");

endmodule

// ==== l2_mshr.sv ====
`timescale 1ns/1ps

module l2_mshr #(
    parameter int N_MSHR = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_req_i,
    input  mshr_pkg::mshr_cmd_t   cmd_i,
    output logic                  cmd_ack_o,
    output logic                  hit_o,
    output logic                  set_conflict_o,
    output logic                  fwd_stall_o,
    output logic [IDX_W-1:0]      idx_o,
    output mshr_pkg::mshr_entry_t entry_o,
    output logic                  write_pending_o
);

    localparam int IDX_W = (N_MSHR > 1) ? $clog2(N_MSHR) : 1;

    logic                   accept;
    logic [IDX_W-1:0]       idx_q;
    logic [IDX_W-1:0]       idx_next;
    mshr_pkg::mshr_search_t search_res;
    mshr_pkg::mshr_search_t result_q;
    mshr_pkg::mshr_entry_t  entries [N_MSHR];

    // handshake, accept strobe and registered results
    mshr_cmd_ctrl #(
        .N_MSHR (N_MSHR)
    ) u_cmd_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cmd_req_i  (cmd_req_i),
        .kind_i     (cmd_i.kind),
        .result_i   (search_res),
        .idx_next_i (idx_next),
        .cmd_ack_o  (cmd_ack_o),
        .accept_o   (accept),
        .result_o   (result_q),
        .idx_o      (idx_q)
    );

    // writes land at the index of the last search
    mshr_entry_array #(
        .N_MSHR (N_MSHR)
    ) u_entry_array (
        .clk       (clk),
        .rst       (rst),
        .accept_i  (accept),
        .cmd_i     (cmd_i),
        .idx_i     (idx_q),
        .entries_o (entries)
    );

    mshr_search #(
        .N_MSHR (N_MSHR)
    ) u_search (
        .cmd_i           (cmd_i),
        .entries_i       (entries),
        .result_o        (search_res),
        .idx_next_o      (idx_next),
        .write_pending_o (write_pending_o)
    );

    assign hit_o          = result_q.hit;
    assign set_conflict_o = result_q.set_conflict;
    // stalled entry is idx_o while fwd_stall_o is high
    assign fwd_stall_o    = result_q.fwd_stall;
    assign idx_o          = idx_q;
    assign entry_o        = entries[idx_q];

endmodule

// ==== mshr_checker.sv ====
`timescale 1ns/1ps

module mshr_checker #(
    parameter int N_MSHR = 4,
    localparam int IDX_W = (N_MSHR > 1) ? $clog2(N_MSHR) : 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_req_i,
    input  mshr_pkg::mshr_cmd_t   cmd_i,
    input  logic                  cmd_ack_i,
    input  logic                  hit_i,
    input  logic                  set_conflict_i,
    input  logic                  fwd_stall_i,
    input  logic [IDX_W-1:0]      idx_i,
    input  mshr_pkg::mshr_entry_t entry_i,
    input  logic                  write_pending_i,
    output int                    check_cnt_o,
    output int                    error_cnt_o
);

    // shadow copy of the buffer and of the held index
    mshr_pkg::mshr_entry_t  shadow [N_MSHR];
    logic [IDX_W-1:0]       shadow_idx;
    mshr_pkg::mshr_search_t expect_res;
    logic                   ack_prev;
    int                     checks = 0;
    int                     errors = 0;

    // forward waits unless invalidation, or a read-type forward hits an RI line
    function automatic logic forward_must_stall(
        input logic [mshr_pkg::MSG_W-1:0]   msg,
        input logic [mshr_pkg::STATE_W-1:0] state
    );
        if (msg == mshr_pkg::FWD_INV) begin
            return 1'b0;
        end
        if (state == mshr_pkg::SPX_RI &&
            (msg == mshr_pkg::FWD_RVK_O || msg == mshr_pkg::FWD_REQ_S ||
             msg == mshr_pkg::FWD_REQ_ODATA || msg == mshr_pkg::FWD_WTFWD)) begin
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic logic is_search(input logic [mshr_pkg::CMD_W-1:0] kind);
        return kind == mshr_pkg::CMD_LOOKUP || kind == mshr_pkg::CMD_PEEK_REQ ||
               kind == mshr_pkg::CMD_PEEK_FLUSH || kind == mshr_pkg::CMD_PEEK_FWD;
    endfunction

    // reference result of one command against the shadow buffer
    function automatic mshr_pkg::mshr_search_t predict(
        input  mshr_pkg::mshr_cmd_t c,
        output logic [IDX_W-1:0]    idx
    );
        mshr_pkg::mshr_search_t r;
        logic                   live;
        logic                   same_set;
        r   = '0;
        idx = '0;
        // walk upward so the highest entry is the one kept
        for (int i = 0; i < N_MSHR; i++) begin
            live     = (shadow[i].state != mshr_pkg::SPX_I);
            same_set = live && (shadow[i].set == c.set);
            if (c.kind == mshr_pkg::CMD_LOOKUP || c.kind == mshr_pkg::CMD_PEEK_FWD) begin
                if (same_set && shadow[i].tag == c.tag) begin
                    r.hit = 1'b1;
                    idx   = IDX_W'(i);
                    if (c.kind == mshr_pkg::CMD_PEEK_FWD) begin
                        r.fwd_stall = forward_must_stall(c.fwd_msg, shadow[i].state);
                    end
                end
            end else if (c.kind == mshr_pkg::CMD_PEEK_REQ ||
                         c.kind == mshr_pkg::CMD_PEEK_FLUSH) begin
                if (!live) begin
                    idx = IDX_W'(i);
                end
                if (c.kind == mshr_pkg::CMD_PEEK_REQ && same_set) begin
                    r.set_conflict = 1'b1;
                end
            end
        end
        return r;
    endfunction

    // entry after an ADD or UPDATE, searches leave it alone
    function automatic mshr_pkg::mshr_entry_t apply_write(
        input mshr_pkg::mshr_entry_t old,
        input mshr_pkg::mshr_cmd_t   c
    );
        mshr_pkg::mshr_entry_t e;
        e = old;
        if (c.kind == mshr_pkg::CMD_ADD) begin
            e.state     = c.state;
            e.tag       = c.tag;
            e.set       = c.set;
            e.way       = c.way;
            e.w_off     = c.w_off;
            e.cpu_msg   = c.cpu_msg;
            e.word      = c.word;
            e.line      = c.line;
            e.word_mask = c.word_mask;
        end else if (c.kind == mshr_pkg::CMD_UPDATE) begin
            if (c.upd_state) e.state = c.state;
            if (c.upd_line) e.line = c.line;
            if (c.upd_tag) e.tag = c.tag;
            if (c.upd_word_mask) e.word_mask = c.word_mask;
        end
        return e;
    endfunction

    function automatic logic any_write_pending();
        logic wp;
        wp = 1'b0;
        for (int i = 0; i < N_MSHR; i++) begin
            case (shadow[i].state)
                mshr_pkg::SPX_XR, mshr_pkg::SPX_XRV, mshr_pkg::SPX_AMO: wp = 1'b1;
                default: ;
            endcase
        end
        return wp;
    endfunction

    task automatic compare(input string name, input logic [255:0] expv,
                           input logic [255:0] actv);
        if (actv !== expv) begin
            $display("Error: %s expected %0h got %0h", name, expv, actv);
            errors++;
        end
    endtask

    // accept is req high with ack still low at the edge
    always @(posedge clk or negedge rst) begin : track
        mshr_pkg::mshr_search_t res;
        logic [IDX_W-1:0]       nidx;
        if (!rst) begin
            for (int i = 0; i < N_MSHR; i++) begin
                shadow[i] <= '0;
            end
            shadow_idx <= '0;
            expect_res <= '0;
        end else if (cmd_req_i && !cmd_ack_i) begin
            res = predict(cmd_i, nidx);
            expect_res <= res;
            if (is_search(cmd_i.kind)) begin
                shadow_idx <= nidx;
            end
            shadow[shadow_idx] <= apply_write(shadow[shadow_idx], cmd_i);
        end
    end

    // outputs settle well before the falling edge of the ack-rise cycle
    always @(negedge clk or negedge rst) begin
        if (!rst) begin
            ack_prev <= 1'b0;
        end else begin
            ack_prev <= cmd_ack_i;
            if (cmd_ack_i && !ack_prev) begin
                checks++;
                compare("hit_o", expect_res.hit, hit_i);
                compare("set_conflict_o", expect_res.set_conflict, set_conflict_i);
                compare("fwd_stall_o", expect_res.fwd_stall, fwd_stall_i);
                compare("idx_o", shadow_idx, idx_i);
                compare("entry_o", shadow[shadow_idx], entry_i);
                compare("write_pending_o", any_write_pending(), write_pending_i);
            end
        end
    end

    assign check_cnt_o = checks;
    assign error_cnt_o = errors;

endmodule

// ==== tb_l2_mshr.sv ====
`timescale 1ns/1ps

module tb_l2_mshr;

    localparam int N_MSHR      = 4;
    localparam int IDX_W       = (N_MSHR > 1) ? $clog2(N_MSHR) : 1;
    localparam int ACK_TIMEOUT = 50;

    logic                  clk;
    logic                  rst;
    logic                  cmd_req;
    mshr_pkg::mshr_cmd_t   cmd;
    logic                  cmd_ack;
    logic                  hit;
    logic                  set_conflict;
    logic                  fwd_stall;
    logic [IDX_W-1:0]      idx;
    mshr_pkg::mshr_entry_t entry;
    logic                  write_pending;

    int check_cnt;
    int error_cnt;
    int sent_cnt;
    int timeout_cnt;

    // addresses placed in the buffer by the stimulus
    logic [mshr_pkg::TAG_W-1:0] tags [N_MSHR];
    logic [mshr_pkg::SET_W-1:0] sets [N_MSHR];
    logic                       live [N_MSHR];

    mshr_pkg::mshr_cmd_t        c;
    logic [31:0]                r;
    logic [mshr_pkg::SET_W-1:0] free_set;
    logic                       used;
    int                         k;

    l2_mshr #(
        .N_MSHR (N_MSHR)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .cmd_req_i       (cmd_req),
        .cmd_i           (cmd),
        .cmd_ack_o       (cmd_ack),
        .hit_o           (hit),
        .set_conflict_o  (set_conflict),
        .fwd_stall_o     (fwd_stall),
        .idx_o           (idx),
        .entry_o         (entry),
        .write_pending_o (write_pending)
    );

    mshr_checker #(
        .N_MSHR (N_MSHR)
    ) u_checker (
        .clk             (clk),
        .rst             (rst),
        .cmd_req_i       (cmd_req),
        .cmd_i           (cmd),
        .cmd_ack_i       (cmd_ack),
        .hit_i           (hit),
        .set_conflict_i  (set_conflict),
        .fwd_stall_i     (fwd_stall),
        .idx_i           (idx),
        .entry_i         (entry),
        .write_pending_i (write_pending),
        .check_cnt_o     (check_cnt),
        .error_cnt_o     (error_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // command with random payload around a given address
    function automatic mshr_pkg::mshr_cmd_t make_cmd(
        input logic [mshr_pkg::CMD_W-1:0] kind,
        input logic [mshr_pkg::TAG_W-1:0] tag,
        input logic [mshr_pkg::SET_W-1:0] set
    );
        mshr_pkg::mshr_cmd_t m;
        logic [31:0]         v;
        m      = '0;
        m.kind = kind;
        m.tag  = tag;
        m.set  = set;
        v      = $urandom();
        m.w_off     = v[1:0];
        m.way       = v[4:2];
        m.cpu_msg   = v[6:5];
        m.word_mask = v[10:7];
        m.word      = $urandom();
        m.line      = {$urandom(), $urandom(), $urandom(), $urandom()};
        return m;
    endfunction

    function automatic logic [mshr_pkg::STATE_W-1:0] pick_state(input logic allow_free);
        case ($urandom_range(5, allow_free ? 0 : 1))
            0: return mshr_pkg::SPX_I;
            1: return mshr_pkg::SPX_IS;
            2: return mshr_pkg::SPX_RI;
            3: return mshr_pkg::SPX_XR;
            4: return mshr_pkg::SPX_XRV;
            default: return mshr_pkg::SPX_AMO;
        endcase
    endfunction

    // one four-phase exchange
    task automatic send_cmd(input mshr_pkg::mshr_cmd_t m);
        int waited;
        @(posedge clk);
        cmd_req <= 1'b1;
        cmd     <= m;
        sent_cnt++;
        waited = 0;
        while (cmd_ack !== 1'b1 && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (cmd_ack !== 1'b1) begin
            $display("timed out waiting for ack to rise, command kind %0d", m.kind);
            timeout_cnt++;
        end
        cmd_req <= 1'b0;
        waited = 0;
        while (cmd_ack !== 1'b0 && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (cmd_ack !== 1'b0) begin
            $display("timed out waiting for ack to fall, command kind %0d", m.kind);
            timeout_cnt++;
        end
    endtask

    initial begin
        rst         = 1'b0;
        cmd_req     = 1'b0;
        cmd         = '0;
        sent_cnt    = 0;
        timeout_cnt = 0;
        void'($urandom(32'h75eb_b160));
        repeat (5) @(posedge clk);
        rst <= 1'b1;

        // empty buffer
        r = $urandom();
        send_cmd(make_cmd(mshr_pkg::CMD_PEEK_FLUSH, r[9:0], r[13:10]));
        send_cmd(make_cmd(mshr_pkg::CMD_LOOKUP, r[9:0], r[13:10]));

        // fill, low tag bits keep every address distinct
        for (k = 0; k < N_MSHR; k++) begin
            r = $urandom();
            tags[k] = {r[7:0], k[1:0]};
            sets[k] = r[11:8];
            live[k] = 1'b1;
            send_cmd(make_cmd(mshr_pkg::CMD_PEEK_REQ, tags[k], sets[k]));
            c = make_cmd(mshr_pkg::CMD_ADD, tags[k], sets[k]);
            c.state = pick_state(1'b0);
            send_cmd(c);
        end
        send_cmd(make_cmd(mshr_pkg::CMD_PEEK_FLUSH, tags[0], sets[0]));
        for (k = 0; k < N_MSHR; k++) begin
            send_cmd(make_cmd(mshr_pkg::CMD_LOOKUP, tags[k], sets[k]));
        end

        // set conflict, then a set nobody holds
        send_cmd(make_cmd(mshr_pkg::CMD_PEEK_REQ, tags[0] ^ 10'h3fc, sets[0]));
        free_set = sets[0];
        for (int s = 0; s < 16; s++) begin
            used = 1'b0;
            for (int j = 0; j < N_MSHR; j++) begin
                if (sets[j] == s[3:0]) used = 1'b1;
            end
            if (!used) free_set = s[3:0];
        end
        send_cmd(make_cmd(mshr_pkg::CMD_PEEK_REQ, tags[1], free_set));

        // entry 0 in RI, entry 1 in XR
        send_cmd(make_cmd(mshr_pkg::CMD_LOOKUP, tags[0], sets[0]));
        c = make_cmd(mshr_pkg::CMD_UPDATE, tags[0], sets[0]);
        c.upd_state = 1'b1;
        c.state     = mshr_pkg::SPX_RI;
        send_cmd(c);
        send_cmd(make_cmd(mshr_pkg::CMD_LOOKUP, tags[1], sets[1]));
        c = make_cmd(mshr_pkg::CMD_UPDATE, tags[1], sets[1]);
        c.upd_state = 1'b1;
        c.state     = mshr_pkg::SPX_XR;
        send_cmd(c);

        // every forward message against RI, another state and a miss
        for (int msg = 0; msg < 6; msg++) begin
            for (int t = 0; t < 3; t++) begin
                c = make_cmd(mshr_pkg::CMD_PEEK_FWD, tags[t == 1],
                             (t == 1) ? sets[1] : sets[0]);
                if (t == 2) c.tag = tags[0] ^ 10'h3fc;
                c.fwd_msg = msg[4:0];
                send_cmd(c);
            end
        end

        // random partial updates on live entries
        for (int n = 0; n < 24; n++) begin
            k = $urandom_range(N_MSHR - 1, 0);
            if (!live[k]) continue;
            send_cmd(make_cmd(mshr_pkg::CMD_LOOKUP, tags[k], sets[k]));
            r = $urandom();
            if (r[3:0] == 4'd0) r[0] = 1'b1;
            c = make_cmd(mshr_pkg::CMD_UPDATE, {r[15:8], k[1:0]}, sets[k]);
            c.upd_state     = r[0];
            c.upd_line      = r[1];
            c.upd_tag       = r[2];
            c.upd_word_mask = r[3];
            c.state         = pick_state(1'b1);
            send_cmd(c);
            if (c.upd_tag) tags[k] = c.tag;
            if (c.upd_state && c.state == mshr_pkg::SPX_I) live[k] = 1'b0;
        end
        send_cmd(make_cmd(mshr_pkg::CMD_PEEK_FLUSH, tags[0], sets[0]));
        for (k = 0; k < N_MSHR; k++) begin
            send_cmd(make_cmd(mshr_pkg::CMD_LOOKUP, tags[k], sets[k]));
        end

        repeat (2) @(posedge clk);
        if (check_cnt != sent_cnt) begin
            $display("compared %0d responses but sent %0d commands", check_cnt, sent_cnt);
        end
        $display("checks %0d, value errors %0d, timeouts %0d",
                 check_cnt, error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0 && check_cnt == sent_cnt) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
mshr_pkg.sv
mshr_entry_array.sv
mshr_search.sv
mshr_cmd_ctrl.sv
l2_mshr.sv
mshr_checker.sv
tb_l2_mshr.sv

// ==== Bender.yml ====
package:
  name: l2_mshr

sources:
  - mshr_pkg.sv
  - mshr_entry_array.sv
  - mshr_search.sv
  - mshr_cmd_ctrl.sv
  - l2_mshr.sv
  - target: test
    files:
      - mshr_checker.sv
      - tb_l2_mshr.sv
